/* filelist.f */
+incdir+rtl
rtl/mem_miss_pkg.sv
rtl/mshr_if.sv
rtl/miss_decode.sv
rtl/mshr_file.sv
rtl/fill_requester.sv
rtl/fill_result.sv
rtl/miss_top.sv
test/tb_clock.sv
test/miss_checker.sv
test/miss_tb.sv

/* run.sh */
#!/bin/sh
# build and run the MSHR testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module miss_tb -f filelist.f -o miss_sim \
    && ./obj_dir/miss_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Errors found" sim.log && { echo "simulation FAILED"; exit 1; }
exit 0

/* test/miss_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mem_miss_cfg.svh"

module miss_tb import mem_miss_pkg::*; ();

    localparam int WAIT_LIMIT = 400;

    logic       clk;
    logic       arst_n;
    logic       req_valid;
    paddr_t     req_paddr;
    qslot_t     req_slot;
    logic       req_is_store;
    logic       req_ready;
    paddr_t     apb_paddr;
    logic       apb_psel;
    logic       apb_penable;
    line_data_t apb_prdata = '0;
    logic       apb_pready = 1'b0;
    logic       wake_valid;
    qslot_t     wake_slots;
    wake_t      wake_vector;
    line_data_t wake_data;
    logic       mshr_hit;
    logic       mshr_full;

    // checker side
    logic [2:0] test_id;
    string      test_label;
    paddr_t     model_head;
    line_data_t head_fill;
    int         model_size;
    int         chk_errors;
    int         wake_count;
    int         fetch_count;
    int         tb_errors;

    // memory model controls
    logic        pready_hold;
    logic        rand_delay;
    int          fixed_delay;
    int          wait_left;
    logic [31:0] delay_rng;
    logic [31:0] stim_rng;

    // last wake-up seen on the port
    qslot_t     last_slots;
    wake_t      last_vector;
    line_data_t last_data;

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1103515245 + 32'd12345;
    endfunction

    // memory contents of a line
    function automatic line_data_t fill_value(input paddr_t a);
        return lcg_next({17'b0, a} ^ 32'h72d2);
    endfunction

    assign head_fill = fill_value(model_head);

    tb_clock tb_clock_inst (
        .clk    (clk),
        .arst_n (arst_n)
    );

    miss_top miss_top_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .req_valid    (req_valid),
        .req_paddr    (req_paddr),
        .req_slot     (req_slot),
        .req_is_store (req_is_store),
        .req_ready    (req_ready),
        .apb_paddr    (apb_paddr),
        .apb_psel     (apb_psel),
        .apb_penable  (apb_penable),
        .apb_prdata   (apb_prdata),
        .apb_pready   (apb_pready),
        .wake_valid   (wake_valid),
        .wake_slots   (wake_slots),
        .wake_vector  (wake_vector),
        .wake_data    (wake_data),
        .mshr_hit     (mshr_hit),
        .mshr_full    (mshr_full)
    );

    miss_checker miss_checker_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .test_id      (test_id),
        .req_valid    (req_valid),
        .req_paddr    (req_paddr),
        .req_slot     (req_slot),
        .req_is_store (req_is_store),
        .req_ready    (req_ready),
        .mshr_hit     (mshr_hit),
        .mshr_full    (mshr_full),
        .apb_paddr    (apb_paddr),
        .apb_psel     (apb_psel),
        .apb_penable  (apb_penable),
        .apb_pready   (apb_pready),
        .wake_valid   (wake_valid),
        .wake_slots   (wake_slots),
        .wake_vector  (wake_vector),
        .wake_data    (wake_data),
        .head_fill    (head_fill),
        .model_head   (model_head),
        .model_size   (model_size),
        .err_count    (chk_errors),
        .wake_count   (wake_count),
        .fetch_count  (fetch_count)
    );

    ////////////////////////////////////////
    // apb memory model
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (!arst_n) begin
            apb_pready = 1'b0;
            wait_left  = 0;
            delay_rng  = lcg_next(32'h72d2);
        end else if (apb_psel && !apb_penable) begin  // setup
            delay_rng  = lcg_next(delay_rng);
            wait_left  = rand_delay ? int'(delay_rng[17:16]) : fixed_delay;
            apb_pready = 1'b0;
        end else if (apb_psel && !pready_hold && wait_left == 0) begin
            apb_pready = 1'b1;
        end else begin
            if (apb_psel && !pready_hold)
                wait_left--;
            apb_pready = 1'b0;
        end
        apb_prdata = apb_psel ? fill_value(apb_paddr) : '0;
    end

    always @(negedge clk) begin
        if (wake_valid) begin
            last_slots  = wake_slots;
            last_vector = wake_vector;
            last_data   = wake_data;
        end
    end

    task automatic start_test(input logic [2:0] id, input string name);
        @(negedge clk);
        test_id    = id;
        test_label = name;
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s %s: expected %h, actual %h", test_label, what, exp, act);
            tb_errors++;
        end
    endtask

    // holds the request until the edge that takes it
    task automatic send_req(input paddr_t a, input qslot_t s, input logic st);
        int   waited;
        logic taken;
        @(negedge clk);
        req_valid    = 1'b1;
        req_paddr    = a;
        req_slot     = s;
        req_is_store = st;
        waited       = 0;
        taken        = 1'b0;
        while (!taken && waited < WAIT_LIMIT) begin
            @(posedge clk);
            taken = req_ready;
            waited++;
        end
        if (!taken) begin
            $display("%s: request to line %h was never accepted", test_label, a);
            tb_errors++;
        end
    endtask

    task automatic req_idle();
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_wakes(input int target);
        int cycles;
        cycles = 0;
        while (wake_count < target && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (wake_count < target) begin
            $display("%s: timed out waiting for wake-up number %0d", test_label, target);
            tb_errors++;
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((model_size != 0 || apb_psel) && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (model_size != 0 || apb_psel) begin
            $display("%s: drain timed out with work still outstanding", test_label);
            tb_errors++;
        end
    endtask

    // room for a stray extra wake-up to show
    task automatic quiet();
        repeat (4) @(negedge clk);
    endtask

    initial begin
        int     base_wakes;
        int     base_fetches;
        int     stalls;
        int     idx;
        int     total;
        paddr_t line;
        req_valid    = 1'b0;
        req_paddr    = '0;
        req_slot     = '0;
        req_is_store = 1'b0;
        pready_hold  = 1'b0;
        rand_delay   = 1'b0;
        fixed_delay  = 0;
        stim_rng     = 32'h72d2;
        tb_errors    = 0;
        test_id      = 3'd0;
        test_label   = "reset";

        // wait out the reset
        repeat (3) @(negedge clk);
        start_test(3'd0, "reset");
        check_value("apb_psel", 0, 32'(apb_psel));
        check_value("apb_penable", 0, 32'(apb_penable));
        check_value("wake_valid", 0, 32'(wake_valid));
        check_value("req_ready", 1, 32'(req_ready));
        check_value("mshr_full", 0, 32'(mshr_full));

        start_test(3'd1, "single_miss");
        fixed_delay  = 2;
        base_wakes   = wake_count;
        base_fetches = fetch_count;
        send_req(15'h1234, 8'h04, 1'b0);
        req_idle();
        wait_wakes(base_wakes + 1);
        quiet();
        check_value("wake count", base_wakes + 1, wake_count);
        check_value("fetch count", base_fetches + 1, fetch_count);
        check_value("wake_slots", 'h04, 32'(last_slots));
        check_value("wake_vector", 'b01, 32'(last_vector));
        check_value("wake_data", fill_value(15'h1234), last_data);

        start_test(3'd2, "merge");
        fixed_delay  = 4;
        base_wakes   = wake_count;
        base_fetches = fetch_count;
        send_req(15'h0a0a, 8'h01, 1'b0);
        send_req(15'h0a0a, 8'h10, 1'b1);  // lands while the line is in flight
        req_idle();
        wait_wakes(base_wakes + 1);
        quiet();
        check_value("wake count", base_wakes + 1, wake_count);
        check_value("fetch count", base_fetches + 1, fetch_count);
        check_value("wake_slots", 'h11, 32'(last_slots));
        check_value("wake_vector", 'b01, 32'(last_vector));
        check_value("wake_data", fill_value(15'h0a0a), last_data);

        ////////////////////////////////////////
        // fill the store under a stalled fetch
        ////////////////////////////////////////

        start_test(3'd3, "full_stall");
        fixed_delay  = 1;
        pready_hold  = 1'b1;
        base_wakes   = wake_count;
        base_fetches = fetch_count;
        for (int i = 0; i < `MSHR_DEPTH; i++)
            send_req(paddr_t'(15'h0300 + i * 15'h0011), qslot_t'(1) << i, i[0]);
        req_idle();
        check_value("mshr_full", 1, 32'(mshr_full));
        send_req(15'h0322, 8'h80, 1'b1);  // merge into a live line
        fork
            send_req(15'h7f00, 8'h40, 1'b0);
            begin
                stalls = 0;
                repeat (4) begin
                    @(posedge clk);
                    if (!req_ready)
                        stalls++;
                end
                check_value("stall cycles", 4, stalls);
                pready_hold = 1'b0;
            end
        join
        req_idle();
        wait_wakes(base_wakes + `MSHR_DEPTH + 1);
        quiet();
        check_value("wake count", base_wakes + `MSHR_DEPTH + 1, wake_count);
        check_value("fetch count", base_fetches + `MSHR_DEPTH + 1, fetch_count);

        start_test(3'd4, "ordering");
        fixed_delay  = 1;
        base_wakes   = wake_count;
        base_fetches = fetch_count;
        for (int i = 0; i < 6; i++)
            send_req(paddr_t'(15'h5000 + i * 15'h0101), qslot_t'(1) << i, i[0]);
        req_idle();
        wait_wakes(base_wakes + 6);
        quiet();
        check_value("wake count", base_wakes + 6, wake_count);
        check_value("fetch count", base_fetches + 6, fetch_count);

        start_test(3'd5, "random");
        rand_delay = 1'b1;
        for (int n = 0; n < 300; n++) begin
            stim_rng = lcg_next(stim_rng);
            idx      = int'(stim_rng[19:16]) % 12;
            line     = paddr_t'(15'h02a0 + idx * 15'h0041);
            if (stim_rng[26:25] == 2'b00)
                req_idle();  // occasional gap
            send_req(line, qslot_t'(1) << stim_rng[22:20], stim_rng[23]);
        end
        req_idle();
        wait_drain();
        quiet();
        check_value("entries left", 0, model_size);

        total = tb_errors + chk_errors;
        $display("errors %0d (checker %0d, stimulus %0d), wake-ups %0d, fetches %0d",
                 total, chk_errors, tb_errors, wake_count, fetch_count);
        if (total == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/miss_checker.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mem_miss_cfg.svh"

module miss_checker import mem_miss_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic [2:0] test_id,
    input  logic       req_valid,
    input  paddr_t     req_paddr,
    input  qslot_t     req_slot,
    input  logic       req_is_store,
    input  logic       req_ready,
    input  logic       mshr_hit,
    input  logic       mshr_full,
    input  paddr_t     apb_paddr,
    input  logic       apb_psel,
    input  logic       apb_penable,
    input  logic       apb_pready,
    input  logic       wake_valid,
    input  qslot_t     wake_slots,
    input  wake_t      wake_vector,
    input  line_data_t wake_data,
    input  line_data_t head_fill,   // reference data for model_head
    output paddr_t     model_head,
    output int         model_size,
    output int         err_count,
    output int         wake_count,
    output int         fetch_count
);

    // model entries in age order
    paddr_t q_paddr[$];
    qslot_t q_slots[$];
    wake_t  q_wake[$];

    // wake-up owed for the next cycle
    logic       wake_due;
    qslot_t     due_slots;
    wake_t      due_wake;
    line_data_t due_data;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd0:    return "reset";
            3'd1:    return "single_miss";
            3'd2:    return "merge";
            3'd3:    return "full_stall";
            3'd4:    return "ordering";
            default: return "random";
        endcase
    endfunction

    task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
        $display("[ERROR] %s %s: expected %h, actual %h", test_name(test_id), what, exp, act);
        err_count++;
    endtask

    task automatic failure(input string what);
        $display("%s: %s", test_name(test_id), what);
        err_count++;
    endtask

    ////////////////////////////////////////
    // compare at every rising edge
    ////////////////////////////////////////

    always @(posedge clk) begin
        logic retiring;
        logic hit;
        int   hit_idx;
        logic exp_ready;
        if (!arst_n) begin
            q_paddr.delete();
            q_slots.delete();
            q_wake.delete();
            wake_due    = 1'b0;
            due_slots   = '0;
            due_wake    = '0;
            due_data    = '0;
            model_head  = '0;
            model_size  = 0;
            err_count   = 0;
            wake_count  = 0;
            fetch_count = 0;
        end else begin
            retiring = apb_psel && apb_penable && apb_pready;

            if (wake_due) begin
                if (!wake_valid) begin
                    failure("wake_valid stayed low in the cycle after a completed fetch");
                end else begin
                    wake_count++;
                    if (wake_slots !== due_slots)
                        mismatch("wake_slots", 32'(due_slots), 32'(wake_slots));
                    if (wake_vector !== due_wake)
                        mismatch("wake_vector", 32'(due_wake), 32'(wake_vector));
                    if (wake_data !== due_data)
                        mismatch("wake_data", due_data, wake_data);
                end
            end else if (wake_valid) begin
                failure("wake_valid rose without a completed fetch");
            end

            // apb address must be the model head for the whole transfer
            if (apb_penable && !apb_psel)
                failure("penable high while psel is low");
            if (apb_psel) begin
                if (q_paddr.size() == 0)
                    failure("APB read issued with no outstanding entry");
                else if (apb_paddr !== q_paddr[0])
                    mismatch("apb_paddr", 32'(q_paddr[0]), 32'(apb_paddr));
                if (!apb_penable)
                    fetch_count++;
            end

            wake_due = 1'b0;
            if (retiring && q_paddr.size() > 0) begin
                wake_due  = 1'b1;
                due_slots = q_slots[0];
                due_wake  = q_wake[0];
                due_data  = head_fill;
            end

            if (mshr_full !== (q_paddr.size() == `MSHR_DEPTH))
                mismatch("mshr_full", 32'(q_paddr.size() == `MSHR_DEPTH), 32'(mshr_full));

            if (req_valid) begin
                hit     = 1'b0;
                hit_idx = 0;
                // a retiring head takes no merges
                for (int i = retiring ? 1 : 0; i < q_paddr.size(); i++) begin
                    if (q_paddr[i] == req_paddr) begin
                        hit     = 1'b1;
                        hit_idx = i;
                    end
                end
                exp_ready = hit || (q_paddr.size() < `MSHR_DEPTH);
                if (req_ready !== exp_ready)
                    mismatch("req_ready", 32'(exp_ready), 32'(req_ready));
                if (mshr_hit !== hit)
                    mismatch("mshr_hit", 32'(hit), 32'(mshr_hit));
                if (req_ready) begin
                    if (hit) begin
                        q_slots[hit_idx] = q_slots[hit_idx] | req_slot;
                    end else begin
                        q_paddr.push_back(req_paddr);
                        q_slots.push_back(req_slot);
                        q_wake.push_back(req_is_store ? 2'b10 : 2'b01);  // {store, load}
                    end
                end
            end

            if (retiring && q_paddr.size() > 0) begin
                void'(q_paddr.pop_front());
                void'(q_slots.pop_front());
                void'(q_wake.pop_front());
            end

            model_size = q_paddr.size();
            model_head = (q_paddr.size() > 0) ? q_paddr[0] : '0;
        end
    end

endmodule

`default_nettype wire

/* test/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk    = 1'b0;
        arst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);  // release away from the active edge
        arst_n = 1'b1;
    end

    always #10 clk = ~clk;  // 20 ns period

endmodule

`default_nettype wire

/* rtl/miss_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mem_miss_cfg.svh"

module miss_top import mem_miss_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,

    // miss requests
    input  logic       req_valid,
    input  paddr_t     req_paddr,
    input  qslot_t     req_slot,
    input  logic       req_is_store,
    output logic       req_ready,

    // line fetch, apb read only
    output paddr_t     apb_paddr,
    output logic       apb_psel,
    output logic       apb_penable,
    input  line_data_t apb_prdata,
    input  logic       apb_pready,

    // wake-up to the queue
    output logic       wake_valid,
    output qslot_t     wake_slots,
    output wake_t      wake_vector,
    output line_data_t wake_data,

    output logic       mshr_hit,
    output logic       mshr_full
);

    logic       head_valid;
    paddr_t     head_paddr;
    qslot_t     head_slots;
    wake_t      head_wake;
    logic       fetch_done;
    line_data_t fetch_data;

    mshr_if mif ();

    ////////////////////////////////////////
    // decode
    ////////////////////////////////////////

    miss_decode miss_decode_inst (
        .req_valid    (req_valid),
        .req_paddr    (req_paddr),
        .req_slot     (req_slot),
        .req_is_store (req_is_store),
        .req_ready    (req_ready),
        .mshr_hit     (mshr_hit),
        .mif          (mif.decode)
    );

    ////////////////////////////////////////
    // execute
    ////////////////////////////////////////

    mshr_file mshr_file_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .mif        (mif.store),
        .fetch_done (fetch_done),
        .head_valid (head_valid),
        .head_paddr (head_paddr),
        .head_slots (head_slots),
        .head_wake  (head_wake),
        .mshr_full  (mshr_full)
    );

    fill_requester fill_requester_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .head_valid  (head_valid),
        .head_paddr  (head_paddr),
        .apb_paddr   (apb_paddr),
        .apb_psel    (apb_psel),
        .apb_penable (apb_penable),
        .apb_prdata  (apb_prdata),
        .apb_pready  (apb_pready),
        .fetch_done  (fetch_done),
        .fetch_data  (fetch_data)
    );

    ////////////////////////////////////////
    // result
    ////////////////////////////////////////

    fill_result fill_result_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_done  (fetch_done),
        .fetch_data  (fetch_data),
        .head_slots  (head_slots),
        .head_wake   (head_wake),
        .wake_valid  (wake_valid),
        .wake_slots  (wake_slots),
        .wake_vector (wake_vector),
        .wake_data   (wake_data)
    );

endmodule

`default_nettype wire

/* rtl/fill_result.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mem_miss_cfg.svh"

module fill_result import mem_miss_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       fetch_done,
    input  line_data_t fetch_data,
    input  qslot_t     head_slots,
    input  wake_t      head_wake,
    output logic       wake_valid,
    output qslot_t     wake_slots,
    output wake_t      wake_vector,
    output line_data_t wake_data
);

    ////////////////////////////////////////
    // wake-up register
    ////////////////////////////////////////

    // slots sampled at retire, earlier merges already in the entry
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wake_valid  <= 1'b0;
            wake_slots  <= '0;
            wake_vector <= '0;
            wake_data   <= '0;
        end else if (fetch_done) begin
            wake_valid  <= 1'b1;
            wake_slots  <= head_slots;
            wake_vector <= head_wake;
            wake_data   <= fetch_data;
        end else begin
            wake_valid  <= 1'b0;  // one cycle only
            wake_slots  <= '0;
            wake_vector <= '0;
            wake_data   <= '0;
        end
    end

endmodule

`default_nettype wire

/* rtl/fill_requester.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mem_miss_cfg.svh"

module fill_requester import mem_miss_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       head_valid,
    input  paddr_t     head_paddr,
    output paddr_t     apb_paddr,
    output logic       apb_psel,
    output logic       apb_penable,
    input  line_data_t apb_prdata,
    input  logic       apb_pready,
    output logic       fetch_done,
    output line_data_t fetch_data
);

    fetch_state_t state_q;
    fetch_state_t state_d;

    ////////////////////////////////////////
    // apb read sequence
    ////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (head_valid) begin
                    state_d = SETUP;
                end
            end
            SETUP: begin
                state_d = ACCESS;  // single setup cycle
            end
            ACCESS: begin
                if (apb_pready) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // address held through setup and access
    always_ff @(posedge clk) begin
        if (state_q == IDLE && head_valid) begin
            apb_paddr <= head_paddr;
        end
    end

    assign apb_psel    = (state_q == SETUP) || (state_q == ACCESS);
    assign apb_penable = (state_q == ACCESS);

    // completing cycle of the transfer
    assign fetch_done = (state_q == ACCESS) && apb_pready;
    assign fetch_data = apb_prdata;

endmodule

`default_nettype wire

/* rtl/mshr_file.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mem_miss_cfg.svh"

module mshr_file import mem_miss_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    mshr_if.store  mif,
    input  logic   fetch_done,
    output logic   head_valid,
    output paddr_t head_paddr,
    output qslot_t head_slots,
    output wake_t  head_wake,
    output logic   mshr_full
);

    // entry storage
    entry_vec_t               valid_q;
    paddr_t [`MSHR_DEPTH-1:0] paddr_q;
    qslot_t [`MSHR_DEPTH-1:0] slots_q;
    wake_t  [`MSHR_DEPTH-1:0] wake_q;

    // age order
    entry_idx_t                   head_ptr;
    entry_idx_t                   tail_ptr;
    logic [$clog2(`MSHR_DEPTH):0] count;
    logic                         full;

    function automatic entry_idx_t next_idx(input entry_idx_t idx);
        return (idx == entry_idx_t'(`MSHR_DEPTH - 1)) ? '0 : idx + 1'b1;
    endfunction

    assign full = (count == ($clog2(`MSHR_DEPTH) + 1)'(`MSHR_DEPTH));

    ////////////////////////////////////////
    // valid bits and pointers
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q  <= '0;
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else begin
            if (mif.do_alloc) begin
                valid_q[tail_ptr] <= 1'b1;
                tail_ptr          <= next_idx(tail_ptr);
            end
            if (fetch_done) begin  // head retires
                valid_q[head_ptr] <= 1'b0;
                head_ptr          <= next_idx(head_ptr);
            end
            case ({mif.do_alloc, fetch_done})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ////////////////////////////////////////
    // entry fields
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (mif.do_alloc) begin
            paddr_q[tail_ptr] <= mif.req_paddr;
            slots_q[tail_ptr] <= mif.req_slot;
            wake_q[tail_ptr]  <= mif.req_wake;
        end
        // merge keeps the original wake vector, head included
        if (mif.do_merge) begin
            slots_q[mif.merge_idx] <= slots_q[mif.merge_idx] | mif.req_slot;
        end
    end

    // back to the decoder
    assign mif.entry_valid  = valid_q;
    assign mif.entry_paddr  = paddr_q;
    assign mif.full         = full;
    assign mif.retire_valid = fetch_done;
    assign mif.retire_idx   = head_ptr;

    // oldest entry, for the fetch and the wake-up
    assign head_valid = valid_q[head_ptr];
    assign head_paddr = paddr_q[head_ptr];
    assign head_slots = slots_q[head_ptr];
    assign head_wake  = wake_q[head_ptr];

    assign mshr_full = full;

endmodule

`default_nettype wire

/* rtl/miss_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mem_miss_cfg.svh"

module miss_decode import mem_miss_pkg::*; (
    input  logic   req_valid,
    input  paddr_t req_paddr,
    input  qslot_t req_slot,
    input  logic   req_is_store,
    output logic   req_ready,
    output logic   mshr_hit,
    mshr_if.decode mif
);

    entry_vec_t hit_vec;
    entry_idx_t hit_idx;
    logic       any_hit;

    ////////////////////////////////////////
    // address match
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < `MSHR_DEPTH; i++) begin
            // a retiring entry no longer takes merges
            hit_vec[i] = mif.entry_valid[i]
                       && (mif.entry_paddr[i] == req_paddr)
                       && !(mif.retire_valid && (mif.retire_idx == entry_idx_t'(i)));
        end
    end

    assign any_hit = |hit_vec;

    // lowest matching entry wins
    always_comb begin
        hit_idx = '0;
        for (int i = `MSHR_DEPTH - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                hit_idx = entry_idx_t'(i);
            end
        end
    end

    ////////////////////////////////////////
    // merge / allocate / stall
    ////////////////////////////////////////

    assign req_ready = any_hit || !mif.full;
    assign mshr_hit  = req_valid && any_hit;

    assign mif.do_merge  = req_valid && any_hit;
    assign mif.do_alloc  = req_valid && !any_hit && !mif.full;
    assign mif.merge_idx = hit_idx;

    assign mif.req_paddr = req_paddr;
    assign mif.req_slot  = req_slot;
    assign mif.req_wake  = {req_is_store, !req_is_store};  // store -> 10, load -> 01

endmodule

`default_nettype wire

/* rtl/mshr_if.sv */
`timescale 1ns/100ps
`default_nettype none

`include "mem_miss_cfg.svh"

interface mshr_if import mem_miss_pkg::*; ();

    // entry file state, seen by the decoder
    entry_vec_t                   entry_valid;
    paddr_t [`MSHR_DEPTH-1:0]     entry_paddr;
    logic                         full;
    logic                         retire_valid;  // head leaves this cycle
    entry_idx_t                   retire_idx;

    // decoder's verdict on the current request
    logic                         do_alloc;
    logic                         do_merge;
    entry_idx_t                   merge_idx;
    paddr_t                       req_paddr;
    qslot_t                       req_slot;
    wake_t                        req_wake;

    modport decode (
        input  entry_valid, entry_paddr, full, retire_valid, retire_idx,
        output do_alloc, do_merge, merge_idx, req_paddr, req_slot, req_wake
    );

    modport store (
        output entry_valid, entry_paddr, full, retire_valid, retire_idx,
        input  do_alloc, do_merge, merge_idx, req_paddr, req_slot, req_wake
    );

endinterface

`default_nettype wire

/* rtl/mem_miss_pkg.sv */
`default_nettype none

`include "mem_miss_cfg.svh"

package mem_miss_pkg;

    ////////////////////////////////////////
    // field types
    ////////////////////////////////////////

    typedef logic [`PADDR_W-1:0] paddr_t;      // line address
    typedef logic [`QSLOT_W-1:0] qslot_t;      // waiting queue slots
    typedef logic [1:0]          wake_t;       // {store, load}
    typedef logic [`DATA_W-1:0]  line_data_t;

    // per-entry flags and entry numbering
    typedef logic [`MSHR_DEPTH-1:0]         entry_vec_t;
    typedef logic [$clog2(`MSHR_DEPTH)-1:0] entry_idx_t;

    // apb read sequencing
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS
    } fetch_state_t;

endpackage

`default_nettype wire

/* rtl/mem_miss_cfg.svh */
`ifndef MEM_MISS_CFG_SVH
`define MEM_MISS_CFG_SVH

////////////////////////////////////////
// miss status holding register sizing
////////////////////////////////////////

// number of outstanding line fetches
`define MSHR_DEPTH 8

// line address, as seen by the cache and the APB side
`define PADDR_W 15

// one bit per load/store queue slot
`define QSLOT_W 8

// word returned by a fill
`define DATA_W 32

`endif
